//--- verilog/squash_defines.svh
// Squash unit global sizes
// Fixed once for the whole core and shared by the package and the RTL

`ifndef SQUASH_DEFINES_SVH
`define SQUASH_DEFINES_SVH

// --------------------
// Request sources
// --------------------

// Pipeline sources that can raise a squash
`define SQ_NUM_REQ 4

// --------------------
// Field widths
// --------------------

// Sequence number width, wraps modulo 2**SQ_SEQ_BITS
`define SQ_SEQ_BITS 5

// Redirect target width
`define SQ_TARGET_BITS 32

`endif

//--- verilog/squash_pkg.sv
// Squash unit types
// Vector typedefs and the packed request, grant and commit messages

`include "squash_defines.svh"

package squash_pkg;

  // --------------------
  // Plain vectors
  // --------------------

  // Instruction sequence number, wraps around
  typedef logic [`SQ_SEQ_BITS-1:0] seq_num_t;

  // Distance from the next-to-commit number
  // Smaller value means older instruction
  typedef logic [`SQ_SEQ_BITS-1:0] seq_age_t;

  // Front-end redirect address
  typedef logic [`SQ_TARGET_BITS-1:0] target_t;

  // One bit per request source
  typedef logic [`SQ_NUM_REQ-1:0] req_mask_t;

  // --------------------
  // Messages
  // --------------------

  // Squash request from a source, also the shape of the grant
  // val is a one-cycle strobe, no ready
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
    target_t  target;
  } squash_msg_t;

  // Commit notification
  // Only the sequence number matters here
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
  } commit_msg_t;

endpackage

//--- verilog/seq_age_tracker.sv
// Commit pointer and wrap-aware age calculation
// Ages are measured from the next instruction expected to commit

`timescale 1ns/10ps

`include "squash_defines.svh"

module seq_age_tracker import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Commit stage notification
  input  commit_msg_t commit,

  // Sequence numbers to age
  input  seq_num_t    req_seq [`SQ_NUM_REQ],
  input  seq_num_t    last_seq,

  // Ages against the current pointer
  output seq_age_t    req_age [`SQ_NUM_REQ],
  output seq_age_t    last_age
);

  // --------------------
  // Commit pointer
  // --------------------

  // Sequence number of the last committed instruction
  seq_num_t commit_ptr;

  // Next instruction expected to commit
  seq_num_t next_seq;

  // All ones after reset so the first expected number is zero
  // New value takes effect on the edge ending the commit cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_ptr <= '1;
    end else if (commit.val) begin
      commit_ptr <= commit.seq_num;
    end
  end

  assign next_seq = seq_num_t'(commit_ptr + 1'b1);

  // --------------------
  // Age conversion
  // --------------------

  // Modulo subtraction handles the wrap
  // Plain magnitude compare on ages then gives program order
  always_comb begin
    for (int i = 0; i < `SQ_NUM_REQ; i++) begin
      req_age[i] = seq_age_t'(req_seq[i] - next_seq);
    end
  end

  // Stored squash aged against the same pointer
  assign last_age = seq_age_t'(last_seq - next_seq);

endmodule

//--- verilog/squash_filter.sv
// Stale squash filter
// Remembers the last granted squash and masks requests that are not older

`timescale 1ns/10ps

`include "squash_defines.svh"

module squash_filter import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Raw request strobes and their ages
  input  req_mask_t   req_val,
  input  seq_age_t    req_age [`SQ_NUM_REQ],

  // Age of the stored squash
  input  seq_age_t    last_age,

  // Commit stage notification
  input  commit_msg_t commit,

  // Unregistered winner from the arbiter
  input  logic        win_val,
  input  seq_num_t    win_seq,

  // Stored squash number, aged by the tracker
  output seq_num_t    last_seq,

  // Requests that may still win
  output req_mask_t   live_mask
);

  // --------------------
  // Stored squash
  // --------------------

  // Set while the last granted instruction is uncommitted
  logic last_val;

  // Commit of the stored number releases the filter
  logic release_hit;

  assign release_hit = commit.val && (commit.seq_num == last_seq);

  // New winner beats a release on the same edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_val <= 1'b0;
    end else if (win_val) begin
      last_val <= 1'b1;
    end else if (last_val && release_hit) begin
      last_val <= 1'b0;
    end
  end

  // Number of the granted instruction
  always_ff @(posedge clk) begin
    if (win_val) begin
      last_seq <= win_seq;
    end
  end

  // --------------------
  // Live mask
  // --------------------

  // Granted instruction and all younger ones are already gone
  // Only strictly older requests survive while the filter is set
  always_comb begin
    for (int i = 0; i < `SQ_NUM_REQ; i++) begin
      live_mask[i] = req_val[i] && (!last_val || (req_age[i] < last_age));
    end
  end

endmodule

//--- verilog/squash_arbiter.sv
// Oldest-first squash arbiter
// Pairwise reduction tree over live requests, lower index wins ties
// The winner is registered onto the grant port

`timescale 1ns/10ps

`include "squash_defines.svh"

module squash_arbiter import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Requests and their ages
  input  squash_msg_t req     [`SQ_NUM_REQ],
  input  seq_age_t    req_age [`SQ_NUM_REQ],

  // Requests that passed the filter
  input  req_mask_t   live_mask,

  // Unregistered winner for the filter
  output logic        win_val,
  output seq_num_t    win_seq,

  // Registered grant toward the front end
  output squash_msg_t gnt
);

  // --------------------
  // Tree storage
  // --------------------

  // Heap layout, node n has children 2n+1 and 2n+2
  // Leaves sit at SQ_NUM_REQ-1 and up, in request order
  localparam int NUM_NODES = 2 * `SQ_NUM_REQ - 1;

  // A candidate carries its age for the compare
  typedef struct packed {
    seq_age_t    age;
    squash_msg_t msg;
  } node_t;

  node_t node [NUM_NODES];

  // Older of two candidates
  // Left child holds the lower indices so it keeps ties
  function automatic node_t oldest(input node_t lhs, input node_t rhs);
    if (lhs.msg.val && (!rhs.msg.val || (lhs.age <= rhs.age))) begin
      return lhs;
    end
    return rhs;
  endfunction

  // --------------------
  // Selection tree
  // --------------------

  always_comb begin
    // Leaves
    for (int k = 0; k < `SQ_NUM_REQ; k++) begin
      node[`SQ_NUM_REQ-1+k].age         = req_age[k];
      node[`SQ_NUM_REQ-1+k].msg.seq_num = req[k].seq_num;
      node[`SQ_NUM_REQ-1+k].msg.target  = req[k].target;
      // Strobe qualified by the filter
      node[`SQ_NUM_REQ-1+k].msg.val     = req[k].val && live_mask[k];
    end

    // Inner nodes, bottom up so children settle first
    for (int n = `SQ_NUM_REQ - 2; n >= 0; n--) begin
      node[n] = oldest(node[2*n+1], node[2*n+2]);
    end
  end

  // Root is the oldest live request
  assign win_val = node[0].msg.val;
  assign win_seq = node[0].msg.seq_num;

  // --------------------
  // Grant register
  // --------------------

  logic     gnt_val_q;
  seq_num_t gnt_seq_q;
  target_t  gnt_target_q;

  // One grant per cycle with a live request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_val_q <= 1'b0;
    end else begin
      gnt_val_q <= win_val;
    end
  end

  // Payload only follows a real winner
  always_ff @(posedge clk) begin
    if (win_val) begin
      gnt_seq_q    <= node[0].msg.seq_num;
      gnt_target_q <= node[0].msg.target;
    end
  end

  assign gnt.val     = gnt_val_q;
  assign gnt.seq_num = gnt_seq_q;
  assign gnt.target  = gnt_target_q;

endmodule

//--- verilog/squash_unit.sv
// Level-one squash unit
// Grants the oldest live squash request each cycle, one cycle later
// Filters requests made stale by an earlier grant until it commits

`timescale 1ns/10ps

`include "squash_defines.svh"

module squash_unit import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Squash requests from the pipeline
  input  squash_msg_t req [`SQ_NUM_REQ],

  // Commit stage notification
  input  commit_msg_t commit,

  // Registered squash grant
  output squash_msg_t gnt
);

  // --------------------
  // Internal wires
  // --------------------

  // Request fields split out
  req_mask_t req_val;
  seq_num_t  req_seq [`SQ_NUM_REQ];

  // Ages from the tracker
  seq_age_t  req_age [`SQ_NUM_REQ];
  seq_age_t  last_age;

  // Filter state and result
  seq_num_t  last_seq;
  req_mask_t live_mask;

  // Winner before the grant register
  logic      win_val;
  seq_num_t  win_seq;

  for (genvar i = 0; i < `SQ_NUM_REQ; i++) begin : g_req_split
    assign req_val[i] = req[i].val;
    assign req_seq[i] = req[i].seq_num;
  end

  // --------------------
  // Blocks
  // --------------------

  seq_age_tracker u_tracker (
    .clk      (clk),
    .rst_n    (rst_n),
    .commit   (commit),
    .req_seq  (req_seq),
    .last_seq (last_seq),
    .req_age  (req_age),
    .last_age (last_age)
  );

  squash_filter u_filter (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_val   (req_val),
    .req_age   (req_age),
    .last_age  (last_age),
    .commit    (commit),
    .win_val   (win_val),
    .win_seq   (win_seq),
    .last_seq  (last_seq),
    .live_mask (live_mask)
  );

  squash_arbiter u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_age   (req_age),
    .live_mask (live_mask),
    .win_val   (win_val),
    .win_seq   (win_seq),
    .gnt       (gnt)
  );

endmodule

//--- bench/squash_scoreboard.sv
// Squash unit scoreboard
// Reference model of the commit pointer, stale filter and oldest-first pick
// Checks the registered grant once per cycle

`timescale 1ns/10ps

`include "squash_defines.svh"

module squash_scoreboard import squash_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  squash_msg_t req [`SQ_NUM_REQ],
  input  commit_msg_t commit,
  input  squash_msg_t gnt,
  output int          error_count,
  output int          check_count
);

  // --------------------
  // Model state
  // --------------------

  seq_num_t ptr;
  logic     filt_val;
  seq_num_t filt_seq;

  // Grant expected after the last edge
  logic     exp_val;
  seq_num_t exp_seq;
  target_t  exp_target;
  logic     primed = 1'b0;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  // Distance past the next-to-commit number, modulo the sequence space
  function automatic seq_age_t rel_age(input seq_num_t seq, input seq_num_t next);
    return seq_age_t'(seq - next);
  endfunction

  // --------------------
  // Reference model
  // --------------------

  // Inputs change on falling edges, so they are stable here
  always @(posedge clk) begin : model
    seq_num_t next_seq;
    seq_age_t best_age;
    seq_age_t age;
    int       best;
    logic     any;
    primed = 1'b1;
    if (!rst_n) begin
      ptr      = '1;
      filt_val = 1'b0;
      filt_seq = '0;
      exp_val  = 1'b0;
    end else begin
      next_seq = seq_num_t'(ptr + 1);
      any      = 1'b0;
      best     = 0;
      best_age = '1;
      // Strict compare in ascending order keeps ties at the lower index
      for (int i = 0; i < `SQ_NUM_REQ; i++) begin
        age = rel_age(req[i].seq_num, next_seq);
        if (req[i].val && (!filt_val || age < rel_age(filt_seq, next_seq))) begin
          if (!any || age < best_age) begin
            any      = 1'b1;
            best     = i;
            best_age = age;
          end
        end
      end
      exp_val = any;
      if (any) begin
        exp_seq    = req[best].seq_num;
        exp_target = req[best].target;
        // Load wins over a release in the same cycle
        filt_val   = 1'b1;
        filt_seq   = req[best].seq_num;
      end else if (filt_val && commit.val && commit.seq_num == filt_seq) begin
        filt_val = 1'b0;
      end
      // New pointer only applies from the next cycle on
      if (commit.val) begin
        ptr = commit.seq_num;
      end
    end
  end

  // --------------------
  // Grant checks
  // --------------------

  // Grant register settled mid-cycle
  always @(negedge clk) begin
    if (primed) begin
      check_count++;
      assert (gnt.val === exp_val) else begin
        $display("** Error @ %0t: gnt.val is %b, expected %b", $time, gnt.val, exp_val);
        error_count++;
      end
      if (exp_val) begin
        assert (gnt.seq_num === exp_seq && gnt.target === exp_target) else begin
          $display("** Error @ %0t: gnt is seq %0d target %h, expected seq %0d target %h",
                   $time, gnt.seq_num, gnt.target, exp_seq, exp_target);
          error_count++;
        end
      end
    end
  end

endmodule

//--- bench/tb_squash_unit.sv
// Squash unit testbench
// Directed cases for age order, wrap, filtering and release before random traffic

`timescale 1ns/10ps

`include "squash_defines.svh"

module tb_squash_unit import squash_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 40;
  localparam int RAND_CYCLES     = 400;
  localparam int PLANNED_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 4;

  logic        clk = 1'b0;
  logic        rst_n;
  squash_msg_t req [`SQ_NUM_REQ];
  commit_msg_t commit;
  squash_msg_t gnt;
  int          sb_errors;
  int          sb_checks;
  int          directed_errors = 0;
  seq_num_t    last_commit = '1;

  always #(CLK_PERIOD / 2) clk = ~clk;

  squash_unit dut (.clk(clk), .rst_n(rst_n), .req(req), .commit(commit), .gnt(gnt));

  squash_scoreboard u_scoreboard (
    .clk(clk), .rst_n(rst_n), .req(req), .commit(commit), .gnt(gnt),
    .error_count(sb_errors), .check_count(sb_checks)
  );

  // --------------------
  // Drive helpers
  // --------------------

  task automatic clear_inputs();
    for (int i = 0; i < `SQ_NUM_REQ; i++) begin
      req[i] = '0;
    end
    commit = '0;
  endtask

  // Move to the next falling edge with all strobes low
  task automatic next_cycle();
    @(negedge clk);
    clear_inputs();
  endtask

  task automatic set_req(input int idx, input seq_num_t seq, input target_t tgt);
    req[idx].val     = 1'b1;
    req[idx].seq_num = seq;
    req[idx].target  = tgt;
  endtask

  task automatic commit_at(input seq_num_t seq);
    commit.val     = 1'b1;
    commit.seq_num = seq;
    last_commit    = seq;
  endtask

  // Grant from the request cycle just finished
  task automatic check_gnt(input logic v, input seq_num_t seq, input target_t tgt);
    assert (gnt.val === v && (!v || (gnt.seq_num === seq && gnt.target === tgt))) else begin
      $display("** Error @ %0t: gnt %b/%0d/%h, expected %b/%0d/%h",
               $time, gnt.val, gnt.seq_num, gnt.target, v, seq, tgt);
      directed_errors++;
    end
  endtask

  // --------------------
  // Watchdog
  // --------------------

  initial begin
    #(CLK_PERIOD * PLANNED_CYCLES * 3 / 2);
    $display("Watchdog expired before the test sequence completed");
    $display(">>> FAIL");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(32'hd4ec));
    rst_n = 1'b0;
    clear_inputs();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Oldest of four wins and the tie at age 17 goes to source 1
    next_cycle();
    set_req(0, 20, 32'h0000_1000);
    set_req(1, 17, 32'h0000_1100);
    set_req(2, 17, 32'h0000_1200);
    set_req(3, 25, 32'h0000_1300);
    next_cycle();
    check_gnt(1'b1, 17, 32'h0000_1100);

    // Each source alone and each one older than the last grant
    for (int i = 0; i < `SQ_NUM_REQ; i++) begin
      next_cycle();
      set_req(i, seq_num_t'(14 - 3 * i), target_t'(32'h8000_0000 + i * 16));
      next_cycle();
      check_gnt(1'b1, seq_num_t'(14 - 3 * i), target_t'(32'h8000_0000 + i * 16));
    end

    // Filter holds 5 so equal and younger ones are dropped
    next_cycle();
    set_req(0, 5, 32'hdead_0005);
    set_req(1, 9, 32'hdead_0009);
    next_cycle();
    check_gnt(1'b0, '0, '0);
    next_cycle();
    set_req(2, 7, 32'hc0de_0007);
    set_req(3, 2, 32'hc0de_0002);
    next_cycle();
    check_gnt(1'b1, 2, 32'hc0de_0002);

    // Commit of 2 releases the filter
    next_cycle();
    commit_at(2);
    // Pointer moves on to 31 where a held 2 would block 10 again
    next_cycle();
    commit_at(31);
    next_cycle();
    set_req(1, 10, 32'h0bad_000a);
    next_cycle();
    check_gnt(1'b1, 10, 32'h0bad_000a);

    // Release and new winner together keep the filter on 8
    next_cycle();
    commit_at(10);
    set_req(0, 8, 32'h1234_0008);
    next_cycle();
    check_gnt(1'b1, 8, 32'h1234_0008);
    next_cycle();
    set_req(2, 8, 32'h5678_0008);
    next_cycle();
    check_gnt(1'b0, '0, '0);

    // Release and then pointer to 29 so 31 sits before the wrap
    next_cycle();
    commit_at(8);
    next_cycle();
    commit_at(29);
    next_cycle();
    set_req(0, 1, 32'haaaa_0001);
    set_req(1, 31, 32'hbbbb_001f);
    next_cycle();
    check_gnt(1'b1, 31, 32'hbbbb_001f);

    // Random traffic near the pointer
    for (int c = 0; c < RAND_CYCLES; c++) begin
      next_cycle();
      for (int i = 0; i < `SQ_NUM_REQ; i++) begin
        if ($urandom_range(1) == 1) begin
          set_req(i, seq_num_t'(last_commit + 1 + $urandom_range(15)), $urandom);
        end
      end
      if ($urandom_range(3) == 0) begin
        commit_at(seq_num_t'(last_commit + $urandom_range(3, 1)));
      end
    end
    repeat (2) next_cycle();

    $display("Errors: scoreboard %0d, directed %0d, grant checks %0d",
             sb_errors, directed_errors, sb_checks);
    if (sb_errors == 0 && directed_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+verilog
verilog/squash_pkg.sv
verilog/seq_age_tracker.sv
verilog/squash_filter.sv
verilog/squash_arbiter.sv
verilog/squash_unit.sv
bench/squash_scoreboard.sv
bench/tb_squash_unit.sv

//--- Bender.yml
package:
  name: squash_unit

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/squash_pkg.sv
      - verilog/seq_age_tracker.sv
      - verilog/squash_filter.sv
      - verilog/squash_arbiter.sv
      - verilog/squash_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/squash_scoreboard.sv
      - bench/tb_squash_unit.sv
